// ==== verilog/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_DATA_WIDTH    8
`define UART_DIVIDER_WIDTH 16
`define UART_FIFO_DEPTH    8
`define UART_REG_NUM       6

`define UART_CONTROL_REG   0
`define UART_STATUS_REG    1
`define UART_DIVIDER_REG   2
`define UART_TX_DATA_REG   3
`define UART_RX_DATA_REG   4
`define UART_PARAM_REG     5

`endif

// ==== verilog/uart_pkg.sv ====
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

    // lsb first: tx_reset is bit 0
    typedef struct packed {
        logic parity_odd;
        logic parity_even;
        logic rx_reset;
        logic tx_reset;
    } uart_control_t;

    // parity_err sits at bit 4
    typedef struct packed {
        logic parity_err;
        logic tx_fifo_full;
        logic rx_fifo_full;
        logic tx_fifo_empty;
        logic rx_fifo_empty;
    } uart_status_t;

    typedef struct packed {
        logic [7:0] reg_num;
        logic [7:0] fifo_depth;
        logic [7:0] data_width;
    } uart_param_t;

    typedef struct packed {
        logic [`UART_DIVIDER_WIDTH-1:0] clk_divider;
        logic                           parity_even;
        logic                           parity_odd;
    } uart_line_cfg_t;

    typedef struct packed {
        logic                        parity_err;
        logic [`UART_DATA_WIDTH-1:0] data;
    } rx_word_t;

    typedef struct packed {
        uart_control_t                  control;
        logic [`UART_DIVIDER_WIDTH-1:0] clk_divider;
        logic [`UART_DATA_WIDTH-1:0]    tx_data;
    } uart_regs_t;

endpackage

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  payload_t in_data_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_data_o,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             push;
    logic             pop;

    assign in_ready_o  = !full_o;
    assign out_valid_o = !empty_o;
    assign out_data_o  = mem[rd_ptr];
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign count_next  = count + push - pop;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count_next;
            full_o  <= count_next == (PTR_W + 1)'(DEPTH);
            empty_o <= count_next == '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_reg_file
    import uart_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    // write channel
    input  logic                        wr_valid_i,
    input  logic [31:0]                 wr_addr_i,
    input  logic [31:0]                 wr_data_i,
    output logic                        wr_ready_o,
    // read channel
    input  logic                        rd_addr_valid_i,
    input  logic [31:0]                 rd_addr_i,
    output logic                        rd_addr_ready_o,
    output logic                        rd_data_valid_o,
    output logic [31:0]                 rd_data_o,
    input  logic                        rd_data_ready_i,
    // queues
    output logic                        tx_push_o,
    output logic [`UART_DATA_WIDTH-1:0] tx_data_o,
    input  logic                        tx_full_i,
    input  logic                        tx_empty_i,
    input  rx_word_t                    rx_word_i,
    input  logic                        rx_valid_i,
    output logic                        rx_pop_o,
    input  logic                        rx_full_i,
    output uart_line_cfg_t              line_cfg_o,
    output logic                        tx_reset_o,
    output logic                        rx_reset_o
);

    uart_regs_t   regs;
    uart_status_t status;
    uart_param_t  param;
    logic [29:0]  wr_idx;
    logic [29:0]  rd_idx;
    logic         wr_en;
    logic         rd_en;
    logic         parity_err;
    logic [31:0]  rd_word;

    assign wr_idx = wr_addr_i[31:2];
    assign rd_idx = rd_addr_i[31:2];
    assign wr_en  = wr_valid_i && wr_ready_o;
    assign rd_en  = rd_addr_valid_i && rd_addr_ready_o;

    // pop only when there is something to pop
    assign rx_pop_o = rd_en && rd_idx == `UART_RX_DATA_REG && rx_valid_i;

    assign status = '{parity_err:    parity_err,
                      tx_fifo_full:  tx_full_i,
                      rx_fifo_full:  rx_full_i,
                      tx_fifo_empty: tx_empty_i,
                      rx_fifo_empty: !rx_valid_i};

    assign param = '{reg_num:    8'(`UART_REG_NUM),
                     fifo_depth: 8'(`UART_FIFO_DEPTH),
                     data_width: 8'(`UART_DATA_WIDTH)};

    assign tx_data_o  = regs.tx_data;
    assign tx_reset_o = regs.control.tx_reset;
    assign rx_reset_o = regs.control.rx_reset;
    assign line_cfg_o = '{clk_divider: regs.clk_divider,
                          parity_even: regs.control.parity_even,
                          parity_odd:  regs.control.parity_odd};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ready_o      <= 1'b0;
            rd_addr_ready_o <= 1'b0;
            rd_data_valid_o <= 1'b0;
            tx_push_o       <= 1'b0;
            parity_err      <= 1'b0;
            regs            <= '0;
        end else begin
            wr_ready_o      <= wr_valid_i && !wr_ready_o; // two cycles per write
            rd_addr_ready_o <= rd_addr_valid_i && !rd_addr_ready_o && !rd_data_valid_o;
            tx_push_o       <= wr_en && wr_idx == `UART_TX_DATA_REG;
            if (rd_en) begin
                rd_data_valid_o <= 1'b1;
            end else if (rd_data_ready_i) begin
                rd_data_valid_o <= 1'b0;
            end
            if (wr_en) begin
                case (wr_idx)
                    `UART_CONTROL_REG: regs.control <= wr_data_i[$bits(uart_control_t)-1:0];
                    `UART_DIVIDER_REG: regs.clk_divider <= wr_data_i[`UART_DIVIDER_WIDTH-1:0];
                    `UART_TX_DATA_REG: regs.tx_data <= wr_data_i[`UART_DATA_WIDTH-1:0];
                    default: ;
                endcase
            end
            // sticky, a new error beats the clear
            if (rx_pop_o && rx_word_i.parity_err) begin
                parity_err <= 1'b1;
            end else if (wr_en && wr_idx == `UART_STATUS_REG && wr_data_i[4]) begin
                parity_err <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (rd_idx)
            `UART_CONTROL_REG: rd_word[$bits(uart_control_t)-1:0] = regs.control;
            `UART_STATUS_REG:  rd_word[$bits(uart_status_t)-1:0]  = status;
            `UART_DIVIDER_REG: rd_word[`UART_DIVIDER_WIDTH-1:0]   = regs.clk_divider;
            `UART_TX_DATA_REG: rd_word[`UART_DATA_WIDTH-1:0]      = regs.tx_data;
            `UART_RX_DATA_REG: rd_word[`UART_DATA_WIDTH-1:0]      = rx_valid_i ? rx_word_i.data : '0;
            `UART_PARAM_REG:   rd_word[$bits(uart_param_t)-1:0]   = param;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rd_data_o <= rd_word; // held until the host takes it
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           uart_rx_i,
    input  uart_line_cfg_t line_cfg_i,
    output rx_word_t       word_o,
    output logic           word_valid_o
);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

    rx_state_t                      state;
    logic                           rx_meta;
    logic                           rx_sync;
    logic                           rx_prev;
    logic [`UART_DIVIDER_WIDTH-1:0] cnt;
    logic [2:0]                     bit_idx;
    logic [`UART_DATA_WIDTH-1:0]    data;
    logic                           par_bad;
    logic                           par_en;
    logic                           par_exp;

    assign par_en  = line_cfg_i.parity_even || line_cfg_i.parity_odd;
    assign par_exp = line_cfg_i.parity_even ? ^data : ~^data; // even wins

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_meta      <= 1'b1;
            rx_sync      <= 1'b1;
            rx_prev      <= 1'b1;
            state        <= IDLE;
            cnt          <= '0;
            bit_idx      <= '0;
            par_bad      <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            rx_meta      <= uart_rx_i;
            rx_sync      <= rx_meta;
            rx_prev      <= rx_sync;
            word_valid_o <= 1'b0;
            if (state != IDLE && cnt != 0) begin
                cnt <= cnt - 1'b1;
            end else begin
                case (state)
                    IDLE: if (line_cfg_i.clk_divider != 0 && rx_prev && !rx_sync) begin
                        state <= START;
                        cnt   <= line_cfg_i.clk_divider >> 1; // half a bit
                    end
                    START: begin
                        state   <= rx_sync ? IDLE : DATA; // glitch, not a start bit
                        cnt     <= line_cfg_i.clk_divider - 1'b1;
                        bit_idx <= '0;
                        par_bad <= 1'b0;
                    end
                    DATA: begin
                        data    <= {rx_sync, data[`UART_DATA_WIDTH-1:1]};
                        cnt     <= line_cfg_i.clk_divider - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= par_en ? PARITY : STOP;
                        end
                    end
                    PARITY: begin
                        par_bad <= rx_sync != par_exp;
                        cnt     <= line_cfg_i.clk_divider - 1'b1;
                        state   <= STOP;
                    end
                    STOP: begin
                        word_valid_o <= 1'b1;
                        state        <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == STOP && cnt == 0) begin
            word_o <= '{parity_err: par_bad || !rx_sync, data: data}; // bad stop bit too
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  uart_line_cfg_t              line_cfg_i,
    input  logic [`UART_DATA_WIDTH-1:0] data_i,
    input  logic                        valid_i,
    output logic                        ready_o,
    output logic                        uart_tx_o
);

    localparam int FRAME_W = `UART_DATA_WIDTH + 3;

    logic [FRAME_W-1:0]             shift;
    logic [`UART_DIVIDER_WIDTH-1:0] baud_cnt;
    logic [3:0]                     bit_cnt;
    logic                           busy;
    logic                           par_en;
    logic                           par_bit;

    assign par_en    = line_cfg_i.parity_even || line_cfg_i.parity_odd;
    assign par_bit   = line_cfg_i.parity_even ? ^data_i : ~^data_i;
    assign ready_o   = !busy && line_cfg_i.clk_divider != 0; // divider 0 parks the line
    assign uart_tx_o = shift[0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy     <= 1'b0;
            shift    <= '1; // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (valid_i && ready_o) begin
                busy     <= 1'b1;
                // without parity the spare slot is just a second stop level
                shift    <= {1'b1, par_en ? par_bit : 1'b1, data_i, 1'b0};
                bit_cnt  <= par_en ? 4'(FRAME_W) : 4'(FRAME_W - 1);
                baud_cnt <= line_cfg_i.clk_divider - 1'b1;
            end
        end else if (baud_cnt != 0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else begin
            shift    <= {1'b1, shift[FRAME_W-1:1]};
            baud_cnt <= line_cfg_i.clk_divider - 1'b1;
            bit_cnt  <= bit_cnt - 1'b1;
            if (bit_cnt == 4'd1) begin
                busy <= 1'b0; // end of stop bit
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axil_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module axil_uart
    import uart_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        wr_valid_i,
    input  logic [31:0] wr_addr_i,
    input  logic [31:0] wr_data_i,
    output logic        wr_ready_o,
    input  logic        rd_addr_valid_i,
    input  logic [31:0] rd_addr_i,
    output logic        rd_addr_ready_o,
    output logic        rd_data_valid_o,
    output logic [31:0] rd_data_o,
    input  logic        rd_data_ready_i,
    input  logic        uart_rx_i,
    output logic        uart_tx_o
);

    uart_line_cfg_t              line_cfg;
    logic                        tx_reset;
    logic                        rx_reset;
    logic                        tx_rst;
    logic                        rx_rst;
    logic                        tx_push;
    logic [`UART_DATA_WIDTH-1:0] tx_push_data;
    logic                        tx_full;
    logic                        tx_empty;
    logic [`UART_DATA_WIDTH-1:0] tx_byte;
    logic                        tx_valid;
    logic                        tx_ready;
    rx_word_t                    rx_in_word;
    logic                        rx_in_valid;
    rx_word_t                    rx_out_word;
    logic                        rx_out_valid;
    logic                        rx_pop;
    logic                        rx_full;

    // soft resets from CONTROL act per direction
    assign tx_rst = reset_i || tx_reset;
    assign rx_rst = reset_i || rx_reset;

    uart_reg_file uart_reg_file_i (
        .clk_i, .reset_i,
        .wr_valid_i, .wr_addr_i, .wr_data_i, .wr_ready_o,
        .rd_addr_valid_i, .rd_addr_i, .rd_addr_ready_o,
        .rd_data_valid_o, .rd_data_o, .rd_data_ready_i,
        .tx_push_o (tx_push),      .tx_data_o (tx_push_data),
        .tx_full_i (tx_full),      .tx_empty_i(tx_empty),
        .rx_word_i (rx_out_word),  .rx_valid_i(rx_out_valid),
        .rx_pop_o  (rx_pop),       .rx_full_i (rx_full),
        .line_cfg_o(line_cfg),
        .tx_reset_o(tx_reset),     .rx_reset_o(rx_reset)
    );

    uart_rx uart_rx_i0 (
        .clk_i, .reset_i(rx_rst), .uart_rx_i, .line_cfg_i(line_cfg),
        .word_o(rx_in_word), .word_valid_o(rx_in_valid)
    );

    stream_fifo #(.payload_t(rx_word_t), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo_i (
        .clk_i, .reset_i(rx_rst),
        .in_data_i (rx_in_word),  .in_valid_i (rx_in_valid), .in_ready_o(),
        .out_data_o(rx_out_word), .out_valid_o(rx_out_valid), .out_ready_i(rx_pop),
        .full_o(rx_full), .empty_o()
    );

    stream_fifo #(
        .payload_t(logic [`UART_DATA_WIDTH-1:0]),
        .DEPTH    (`UART_FIFO_DEPTH)
    ) tx_fifo_i (
        .clk_i, .reset_i(tx_rst),
        .in_data_i (tx_push_data), .in_valid_i (tx_push),  .in_ready_o(), // full drops
        .out_data_o(tx_byte),      .out_valid_o(tx_valid), .out_ready_i(tx_ready),
        .full_o(tx_full), .empty_o(tx_empty)
    );

    uart_tx uart_tx_i0 (
        .clk_i, .reset_i(tx_rst), .line_cfg_i(line_cfg),
        .data_i(tx_byte), .valid_i(tx_valid), .ready_o(tx_ready), .uart_tx_o
    );

endmodule

`default_nettype wire

// ==== bench/axil_uart_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_uart_properties (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic hold_valid_i,
    input wire logic hold_ready_i,
    input wire logic full_i,
    input wire logic empty_i
);

    int unsigned fail_count = 0;

    valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
        hold_valid_i && !hold_ready_i |=> hold_valid_i)
        else begin
            fail_count++;
            $error("valid dropped before its transfer");
        end

    // one push per cycle, so an empty queue is never full a cycle later
    no_jump_to_full: assert property (@(posedge clk_i) disable iff (reset_i)
        empty_i |=> !full_i)
        else begin
            fail_count++;
            $error("queue went from empty to full in one cycle");
        end

    // valid is low right after any reset, soft ones included
    idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !hold_valid_i)
        else begin
            fail_count++;
            $error("valid high after reset");
        end

endmodule

bind stream_fifo axil_uart_properties fifo_checks (
    .clk_i(clk_i), .reset_i(reset_i),
    .hold_valid_i(out_valid_o), .hold_ready_i(out_ready_i),
    .full_i(full_o), .empty_i(empty_o)
);

bind uart_reg_file axil_uart_properties regfile_checks (
    .clk_i(clk_i), .reset_i(reset_i),
    .hold_valid_i(rd_data_valid_o), .hold_ready_i(rd_data_ready_i),
    .full_i(tx_full_i), .empty_i(tx_empty_i)
);

`default_nettype wire

// ==== bench/axil_uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module axil_uart_tb;

    localparam int DIV     = 16;
    localparam int BIG_DIV = 64;
    localparam int N_TX    = 4;
    // 20 frames at DIV (tx, rx, parity and reset tests) and 9 at BIG_DIV
    localparam int TIMEOUT = 2 * 11 * ((3 * N_TX + 8) * DIV + 9 * BIG_DIV) + 2000;

    logic        clk_i;
    logic        reset_i         = 1'b1;
    logic        wr_valid_i      = 1'b0;
    logic [31:0] wr_addr_i       = '0;
    logic [31:0] wr_data_i       = '0;
    logic        wr_ready_o;
    logic        rd_addr_valid_i = 1'b0;
    logic [31:0] rd_addr_i       = '0;
    logic        rd_addr_ready_o;
    logic        rd_data_valid_o;
    logic [31:0] rd_data_o;
    logic        rd_data_ready_i = 1'b0;
    logic        uart_rx_i       = 1'b1;
    logic        uart_tx_o;

    int         errors    = 0;
    int         tx_frames = 0;
    int         rd_count  = 0;
    int         cycles    = 0;
    int         cur_div   = 0;
    logic       cur_even  = 1'b0;
    logic       cur_odd   = 1'b0;
    logic [7:0] tx_expect[$];

    axil_uart axil_uart_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // line bits lsb first: start, data, parity, stop; bit 10 is idle without parity
    function automatic logic [10:0] frame_bits(input logic [7:0] data, input logic even,
                                               input logic odd);
        logic ones;
        ones = 1'b0;
        for (int i = 0; i < 8; i++) begin
            ones = ones ^ data[i];
        end
        if (even) begin
            frame_bits = {1'b1, ones, data, 1'b0};
        end else if (odd) begin
            frame_bits = {1'b1, ~ones, data, 1'b0};
        end else begin
            frame_bits = {2'b11, data, 1'b0};
        end
    endfunction

    function automatic void flag_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endfunction

    task automatic bus_write(input int idx, input logic [31:0] data);
        @(posedge clk_i);
        wr_valid_i <= 1'b1;
        wr_addr_i  <= 32'(idx * 4);
        wr_data_i  <= data;
        @(negedge clk_i);
        while (!wr_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        wr_valid_i <= 1'b0; // transfer on this edge
    endtask

    task automatic bus_read(input int idx, output logic [31:0] data);
        @(posedge clk_i);
        rd_addr_valid_i <= 1'b1;
        rd_addr_i       <= 32'(idx * 4);
        @(negedge clk_i);
        while (!rd_addr_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        rd_addr_valid_i <= 1'b0;
        @(negedge clk_i);
        while (!rd_data_valid_o) @(negedge clk_i);
        data = rd_data_o;
        @(posedge clk_i);
        rd_data_ready_i <= 1'b1; // data was held a cycle with ready low
        @(posedge clk_i);
        rd_data_ready_i <= 1'b0;
        rd_count++;
    endtask

    task automatic set_line(input int div, input logic even, input logic odd);
        bus_write(`UART_DIVIDER_REG, 32'(div));
        bus_write(`UART_CONTROL_REG, {28'h0, odd, even, 2'b00});
        cur_div  = div;
        cur_even = even;
        cur_odd  = odd;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        int          nbits;
        bits  = frame_bits(data, cur_even, cur_odd);
        nbits = (cur_even || cur_odd) ? 11 : 10;
        if (bad_parity) begin
            bits[9] = ~bits[9];
        end
        for (int i = 0; i < nbits; i++) begin
            @(posedge clk_i);
            uart_rx_i <= bits[i];
            repeat (cur_div - 1) @(posedge clk_i);
        end
        repeat (cur_div) @(posedge clk_i);
    endtask

    task automatic wait_tx_drained();
        while (tx_expect.size() != 0) @(negedge clk_i);
        repeat (cur_div) @(negedge clk_i);
    endtask

    // tx line monitor, samples every bit at mid-bit
    initial begin : tx_monitor
        logic [10:0] exp_bits;
        int          nbits;
        forever begin
            @(negedge clk_i);
            if (uart_tx_o === 1'b0 && tx_expect.size() == 0) begin
                $display("unexpected frame on uart_tx_o at %0t", $time);
                errors++;
                repeat (11 * cur_div) @(negedge clk_i);
            end else if (uart_tx_o === 1'b0) begin
                exp_bits = frame_bits(tx_expect[0], cur_even, cur_odd);
                nbits    = (cur_even || cur_odd) ? 11 : 10;
                repeat (cur_div / 2) @(negedge clk_i);
                for (int i = 0; i < nbits; i++) begin
                    if (uart_tx_o !== exp_bits[i]) begin
                        flag_mismatch("uart_tx_o", 32'(uart_tx_o), 32'(exp_bits[i]));
                    end
                    if (i < nbits - 1) repeat (cur_div) @(negedge clk_i);
                end
                void'(tx_expect.pop_front());
                tx_frames++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin : main
        logic [31:0] rd;
        logic [7:0]  b;
        logic [7:0]  rx_sent[$];
        int          total;
        void'($urandom(32'h2c66b815));
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        // outputs straight out of reset
        @(negedge clk_i);
        if (uart_tx_o !== 1'b1) flag_mismatch("uart_tx_o", 32'(uart_tx_o), 32'h1);
        if (wr_ready_o !== 1'b0) flag_mismatch("wr_ready_o", 32'(wr_ready_o), 32'h0);
        if (rd_addr_ready_o !== 1'b0) begin
            flag_mismatch("rd_addr_ready_o", 32'(rd_addr_ready_o), 32'h0);
        end
        if (rd_data_valid_o !== 1'b0) begin
            flag_mismatch("rd_data_valid_o", 32'(rd_data_valid_o), 32'h0);
        end

        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h3) flag_mismatch("STATUS", rd, 32'h3);
        bus_read(`UART_PARAM_REG, rd);
        if (rd !== 32'h0006_0808) flag_mismatch("PARAM", rd, 32'h0006_0808);
        bus_write(`UART_CONTROL_REG, 32'hc);
        bus_read(`UART_CONTROL_REG, rd);
        if (rd !== 32'hc) flag_mismatch("CONTROL", rd, 32'hc);
        set_line(DIV, 1'b0, 1'b0);
        bus_read(`UART_DIVIDER_REG, rd);
        if (rd !== 32'(DIV)) flag_mismatch("DIVIDER", rd, 32'(DIV));

        for (int m = 0; m < 3; m++) begin // none, even, odd
            set_line(DIV, m == 1, m == 2);
            repeat (N_TX) begin
                b = 8'($urandom);
                tx_expect.push_back(b);
                bus_write(`UART_TX_DATA_REG, {24'h0, b});
            end
            wait_tx_drained();
        end

        set_line(DIV, 1'b0, 1'b1);
        repeat (4) begin
            b = 8'($urandom);
            rx_sent.push_back(b);
            send_frame(b, 1'b0);
        end
        repeat (4) begin
            bus_read(`UART_RX_DATA_REG, rd);
            b = rx_sent.pop_front();
            if (rd !== {24'h0, b}) flag_mismatch("RX_DATA", rd, {24'h0, b});
        end
        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h3) flag_mismatch("STATUS", rd, 32'h3);

        set_line(DIV, 1'b1, 1'b0);
        send_frame(8'h5a, 1'b1);
        send_frame(8'h3c, 1'b0);
        send_frame(8'hc3, 1'b0);
        bus_read(`UART_RX_DATA_REG, rd);
        if (rd !== 32'h5a) flag_mismatch("RX_DATA", rd, 32'h5a);
        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h12) flag_mismatch("STATUS", rd, 32'h12);
        bus_read(`UART_RX_DATA_REG, rd);
        if (rd !== 32'h3c) flag_mismatch("RX_DATA", rd, 32'h3c);
        bus_read(`UART_RX_DATA_REG, rd);
        if (rd !== 32'hc3) flag_mismatch("RX_DATA", rd, 32'hc3);
        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h13) flag_mismatch("STATUS", rd, 32'h13);
        bus_write(`UART_STATUS_REG, 32'h10);
        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h3) flag_mismatch("STATUS", rd, 32'h3);

        // one byte in the transmitter, eight queued, the tenth dropped
        set_line(BIG_DIV, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            b = 8'($urandom);
            if (i < 9) tx_expect.push_back(b);
            bus_write(`UART_TX_DATA_REG, {24'h0, b});
        end
        bus_read(`UART_STATUS_REG, rd);
        if (rd[3] !== 1'b1) flag_mismatch("STATUS.tx_fifo_full", 32'(rd[3]), 32'h1);
        wait_tx_drained();

        set_line(DIV, 1'b0, 1'b0);
        bus_read(`UART_RX_DATA_REG, rd);
        if (rd !== 32'h0) flag_mismatch("RX_DATA", rd, 32'h0);
        bus_write(`UART_CONTROL_REG, 32'h2);
        send_frame(8'ha5, 1'b0);
        bus_write(`UART_CONTROL_REG, 32'h0);
        bus_read(`UART_STATUS_REG, rd);
        if (rd !== 32'h3) flag_mismatch("STATUS", rd, 32'h3);
        bus_read(`UART_RX_DATA_REG, rd);
        if (rd !== 32'h0) flag_mismatch("RX_DATA", rd, 32'h0);

        total = axil_uart_i.rx_fifo_i.fifo_checks.fail_count
              + axil_uart_i.tx_fifo_i.fifo_checks.fail_count
              + axil_uart_i.uart_reg_file_i.regfile_checks.fail_count;
        $display("tx frames %0d, register reads %0d, check errors %0d, assertion failures %0d",
                 tx_frames, rd_count, errors, total);
        if (errors == 0 && total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== axil_uart.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/stream_fifo.sv
verilog/uart_reg_file.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/axil_uart.sv
bench/axil_uart_properties.sv
bench/axil_uart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f axil_uart.f --top-module axil_uart_tb -Mdir obj_dir

# assertion failures are counted by the testbench, so the run keeps going after one
output=$(./obj_dir/Vaxil_uart_tb +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
